// ==== bch_decode/bch_chien.sv ====
module bch_chien (
	input logic clk,
	input logic reset,
	input logic start,
	input bch_pkg::gf_t sigma1,
	input bch_pkg::gf_t sigma2,
	output logic err,
	output logic valid,
	output logic first,
	output logic last,
	output logic busy
);
	import bch_pkg::*;

	localparam int cnt_w = $clog2(code_n);
	localparam gf_t alpha1 = gf_pow_alpha(1);
	localparam gf_t alpha2 = gf_pow_alpha(2);

	logic [cnt_w-1:0] pos_cnt;
	logic running;
	gf_t term1;
	gf_t term2;

	assign valid = running;
	assign busy = running;
	assign first = running && (pos_cnt == '0);
	assign last = running && (pos_cnt == cnt_w'(code_n - 1));
	// Root when 1 + sigma1 x + sigma2 x^2 = 0.
	assign err = running && ((term1 ^ term2) == 4'h1);

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			pos_cnt <= '0;
		end else if (start) begin
			running <= 1'b1;
			pos_cnt <= '0;
		end else if (running) begin
			pos_cnt <= last ? '0 : pos_cnt + 1'b1;
			if (last)
				running <= 1'b0;
		end
	end

	// Position 14 first, x = alpha^-14 = alpha.
	always_ff @(posedge clk) begin
		if (start) begin
			term1 <= gf_mul(sigma1, alpha1);
			term2 <= gf_mul(sigma2, alpha2);
		end else if (running) begin
			term1 <= gf_mul(term1, alpha1);
			term2 <= gf_mul(term2, alpha2);
		end
	end

endmodule

// ==== bch_decode/bch_key_dec.sv ====
module bch_key_dec (
	input logic clk,
	input logic reset,
	input logic start,
	input bch_pkg::gf_t s1,
	input bch_pkg::gf_t s3,
	input logic accepted,
	output bch_pkg::gf_t sigma1,
	output bch_pkg::gf_t sigma2,
	output bch_pkg::count_t err_count,
	output logic done,
	output logic busy
);
	import bch_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_cube,
		st_solve
	} state_t;

	state_t state;
	gf_t s1_r;
	gf_t s3_r;
	gf_t s1_sq;
	gf_t s1_inv;
	gf_t s1_cube;
	gf_t s3_sum;

	assign s3_sum = s3_r ^ s1_cube; // Zero for a single error.
	assign busy = (state != st_idle) || (done && !accepted);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			done <= 1'b0;
		end else begin
			if (done && accepted)
				done <= 1'b0;
			case (state)
				st_idle: if (start) state <= st_cube;
				st_cube: state <= st_solve;
				st_solve: begin
					state <= st_idle;
					done <= 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			st_idle: begin
				if (start) begin
					s1_r <= s1;
					s3_r <= s3;
					s1_sq <= gf_mul(s1, s1);
					s1_inv <= gf_inv(s1);
				end
			end
			st_cube: s1_cube <= gf_mul(s1_sq, s1_r);
			st_solve: begin
				sigma1 <= s1_r;
				if (s1_r == '0 && s3_r == '0) begin
					sigma2 <= '0;
					err_count <= 2'd0;
				end else if (s3_sum == '0) begin
					sigma2 <= '0;
					err_count <= 2'd1;
				end else begin
					// Peterson form, (S3 + S1^3) / S1.
					sigma2 <= gf_mul(s3_sum, s1_inv);
					err_count <= 2'd2;
				end
			end
			default: ;
		endcase
	end

endmodule

// ==== bch_decode/bch_syndrome.sv ====
module bch_syndrome (
	input logic clk,
	input logic reset,
	input logic start,
	input logic data_in,
	input logic accepted,
	output bch_pkg::gf_t s1,
	output bch_pkg::gf_t s3,
	output logic done,
	output logic busy
);
	import bch_pkg::*;

	localparam int cnt_w = $clog2(code_n);
	localparam gf_t alpha1 = gf_pow_alpha(1);
	localparam gf_t alpha3 = gf_pow_alpha(3);

	logic [cnt_w-1:0] pos_cnt;
	logic running;

	// Stalls only while a finished word waits for the key solver.
	assign busy = done && !accepted;

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			done <= 1'b0;
			pos_cnt <= '0;
		end else begin
			if (done && accepted)
				done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				pos_cnt <= cnt_w'(1);
			end else if (running) begin
				pos_cnt <= pos_cnt + 1'b1;
				if (pos_cnt == cnt_w'(code_n - 1)) begin
					running <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Horner evaluation of r(x) at alpha and alpha^3.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (start) begin
			s1 <= {3'b000, data_in};
			s3 <= {3'b000, data_in};
		end else if (running) begin
			s1 <= gf_mul(s1, alpha1) ^ {3'b000, data_in};
			s3 <= gf_mul(s3, alpha3) ^ {3'b000, data_in};
		end
	end

endmodule

// ==== common/bch_pkg.sv ====
package bch_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// BCH(15,7), t = 2, over GF(16).
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int code_n = 15;
	localparam int data_k = 7;
	localparam int ecc_bits = 8;
	localparam logic [ecc_bits:0] gen_poly = 9'h1d1; // x^8+x^7+x^6+x^4+1.

	typedef logic [3:0] gf_t;
	typedef logic [data_k-1:0] data_t;
	typedef logic [code_n-1:0] code_t; // Bit 14 goes out first.
	typedef logic [1:0] count_t;

	// Shift and add, reducing by x^4+x+1.
	function automatic gf_t gf_mul(input gf_t a, input gf_t b);
		gf_t p;
		gf_t x;
		p = '0;
		x = a;
		for (int k = 0; k < 4; k++) begin
			if (b[k])
				p = p ^ x;
			x = {x[2:0], 1'b0} ^ (x[3] ? 4'h3 : 4'h0);
		end
		return p;
	endfunction

	function automatic gf_t gf_inv(input gf_t a);
		gf_t tbl [16];
		tbl = '{4'h0, 4'h1, 4'h9, 4'he, 4'hd, 4'hb, 4'h7, 4'h6,
			4'hf, 4'h2, 4'hc, 4'h5, 4'ha, 4'h4, 4'h3, 4'h8};
		return tbl[a]; // Zero maps to zero.
	endfunction

	function automatic gf_t gf_pow_alpha(input int i);
		gf_t p;
		p = 4'h1;
		for (int k = 0; k < i % 15; k++)
			p = gf_mul(p, 4'h2);
		return p;
	endfunction

endpackage

// ==== dv/bch_tb.sv ====
module bch_tb;
	import bch_pkg::*;

	logic clk;
	logic reset;
	logic encode_start;
	data_t data_in;
	code_t error;
	logic busy;
	logic wrong;
	logic result_valid;
	code_t result_pattern;
	count_t result_count;

	code_t expected_q[$]; // Injected patterns in issue order.
	code_t pending;
	int accepted_count;
	int results_seen;
	int checks;
	int errors;
	int test_base;

	bch_codec_check #(.stack_depth(6)) uut (
		.clk(clk),
		.reset(reset),
		.encode_start(encode_start),
		.data_in(data_in),
		.error(error),
		.busy(busy),
		.wrong(wrong),
		.result_valid(result_valid),
		.result_pattern(result_pattern),
		.result_count(result_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Popcount by clearing the lowest set bit.
	function automatic count_t expected_count(input code_t p);
		code_t rest;
		int n;
		rest = p;
		n = 0;
		while (rest != '0) begin
			rest = rest & (rest - 1'b1);
			n++;
		end
		return (n > 3) ? count_t'(3) : count_t'(n);
	endfunction

	function automatic code_t random_pattern(input int weight);
		code_t p;
		p = '0;
		while (expected_count(p) < weight)
			p[$urandom % code_n] = 1'b1;
		return p;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Compare tasks and run control.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_pattern(input string name, input code_t got, input code_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d, blocks %0d", checks, errors, accepted_count);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			errors++;
			$display("Timed out waiting for busy to fall.");
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (expected_q.size() != 0 && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (expected_q.size() != 0) begin
			errors++;
			$display("Timed out waiting for %0d results.", expected_q.size());
		end
	endtask

	task automatic run_block(input data_t d, input code_t e);
		wait_idle();
		data_in = d;
		error = e;
		encode_start = 1'b1;
		@(negedge clk);
		encode_start = 1'b0;
	endtask

	// The last result's compare lands in wrong one edge later.
	task automatic end_test(input string name);
		@(negedge clk);
		check_flag("wrong", wrong, 1'b0);
		$display("test %s: %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	// Start seen with busy low at the edge.
	always @(posedge clk) begin
		if (!reset && encode_start && !busy) begin
			expected_q.push_back(error);
			accepted_count++;
		end
	end

	always @(negedge clk) begin
		if (!reset && result_valid) begin
			results_seen++;
			if (expected_q.size() == 0) begin
				errors++;
				$display("A result arrived with no accepted block pending.");
			end else begin
				pending = expected_q.pop_front();
				check_pattern("result_pattern", result_pattern, pending);
				check_count("result_count", result_count, expected_count(pending));
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		int p1;
		int p2;
		int acc0;
		int res0;
		reset = 1'b1;
		encode_start = 1'b0;
		data_in = '0;
		error = '0;
		accepted_count = 0;
		results_seen = 0;
		checks = 0;
		errors = 0;
		test_base = 0;
		void'($urandom(31));
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		check_flag("busy", busy, 1'b0);
		check_flag("result_valid", result_valid, 1'b0);
		end_test("reset");

		run_block(data_t'($urandom), '0);
		wait_drain();
		end_test("zero pattern");

		for (int i = 0; i < code_n; i++)
			run_block(data_t'($urandom), code_t'(1) << i);
		wait_drain();
		end_test("single errors");

		for (int i = 0; i < 20; i++) begin
			p1 = $urandom % code_n;
			p2 = (p1 + 1 + $urandom % (code_n - 1)) % code_n; // Distinct from p1.
			run_block(data_t'($urandom), (code_t'(1) << p1) | (code_t'(1) << p2));
		end
		wait_drain();
		end_test("double errors");

		for (int i = 0; i < 12; i++)
			run_block(data_t'($urandom), random_pattern($urandom % 3));
		wait_drain();
		end_test("back to back");

		acc0 = accepted_count;
		res0 = results_seen;
		for (int b = 0; b < 3; b++) begin
			run_block(data_t'($urandom), random_pattern($urandom % 3));
			for (int k = 0; k < 3; k++) begin
				@(negedge clk);
				check_flag("busy", busy, 1'b1);
				error = random_pattern(2);
				encode_start = 1'b1; // Should be ignored.
				@(negedge clk);
				encode_start = 1'b0;
			end
		end
		wait_drain();
		if (accepted_count - acc0 != 3 || results_seen - res0 != 3) begin
			errors++;
			$display("Expected 3 starts and 3 results, saw %0d starts and %0d results.",
				accepted_count - acc0, results_seen - res0);
		end
		end_test("ignored starts");

		finish_run();
	end

endmodule

// ==== hw/bch_codec_check.sv ====
module bch_codec_check #(
	parameter int stack_depth = 6
) (
	input logic clk,
	input logic reset,
	input logic encode_start,
	input bch_pkg::data_t data_in,
	input bch_pkg::code_t error,
	output logic busy,
	output logic wrong,
	output logic result_valid,
	output bch_pkg::code_t result_pattern,
	output bch_pkg::count_t result_count
);
	import bch_pkg::*;

	logic accept;
	logic enc_bit;
	logic enc_first;
	logic enc_busy;
	code_t flip_sr;
	logic dec_bit;
	gf_t syn_s1;
	gf_t syn_s3;
	logic syn_done;
	logic syn_busy;
	logic syn_handoff;
	gf_t sigma1;
	gf_t sigma2;
	count_t key_count;
	logic key_done;
	logic key_busy;
	logic key_handoff;
	logic ch_err;
	logic ch_valid;
	logic ch_first;
	logic ch_last;
	logic ch_busy;
	code_t pattern_sr;
	count_t count_r;
	code_t exp_pattern;
	count_t exp_count;
	logic exp_present;
	logic pattern_ovf;
	logic count_ovf;
	logic present_ovf;
	logic new_wrong;

	// Weight saturates at 3, past what t = 2 can correct.
	function automatic count_t pattern_weight(input code_t p);
		int n;
		n = 0;
		for (int k = 0; k < code_n; k++)
			n += int'(p[k]);
		return (n > 3) ? 2'd3 : count_t'(n);
	endfunction

	assign accept = encode_start && !enc_busy;
	assign busy = enc_busy;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Encoder and error injection.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	bch_encode u_encode (
		.clk(clk),
		.reset(reset),
		.start(accept),
		.accepted(!syn_busy),
		.data_in(data_in),
		.data_out(enc_bit),
		.first(enc_first),
		.last(),
		.busy(enc_busy)
	);

	// Shifts in step with the encoder.
	always_ff @(posedge clk) begin
		if (accept)
			flip_sr <= error;
		else if (enc_busy && !syn_busy)
			flip_sr <= {flip_sr[code_n-2:0], 1'b0};
	end

	assign dec_bit = enc_bit ^ flip_sr[code_n-1];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decoder chain.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	bch_syndrome u_syndrome (
		.clk(clk),
		.reset(reset),
		.start(enc_first && !syn_busy),
		.data_in(dec_bit),
		.accepted(!key_busy),
		.s1(syn_s1),
		.s3(syn_s3),
		.done(syn_done),
		.busy(syn_busy)
	);

	assign syn_handoff = syn_done && !key_busy;

	bch_key_dec u_key_dec (
		.clk(clk),
		.reset(reset),
		.start(syn_handoff),
		.s1(syn_s1),
		.s3(syn_s3),
		.accepted(!ch_busy),
		.sigma1(sigma1),
		.sigma2(sigma2),
		.err_count(key_count),
		.done(key_done),
		.busy(key_busy)
	);

	assign key_handoff = key_done && !ch_busy;

	bch_chien u_chien (
		.clk(clk),
		.reset(reset),
		.start(key_handoff),
		.sigma1(sigma1),
		.sigma2(sigma2),
		.err(ch_err),
		.valid(ch_valid),
		.first(ch_first),
		.last(ch_last),
		.busy(ch_busy)
	);

	always_ff @(posedge clk) begin
		if (ch_first)
			pattern_sr <= {{(code_n - 1){1'b0}}, ch_err};
		else if (ch_valid)
			pattern_sr <= {pattern_sr[code_n-2:0], ch_err};
		if (key_handoff)
			count_r <= key_count; // Held beside the pattern.
	end

	assign result_pattern = pattern_sr;
	assign result_count = count_r;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Scoreboards and checking.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	expect_fifo #(.depth(stack_depth), .item_t(code_t)) u_pattern_fifo (
		.clk(clk),
		.reset(reset),
		.write(accept),
		.read(result_valid),
		.wdata(error),
		.rdata(exp_pattern),
		.overflow(pattern_ovf)
	);

	expect_fifo #(.depth(stack_depth), .item_t(count_t)) u_count_fifo (
		.clk(clk),
		.reset(reset),
		.write(accept),
		.read(key_handoff),
		.wdata(pattern_weight(error)),
		.rdata(exp_count),
		.overflow(count_ovf)
	);

	expect_fifo #(.depth(stack_depth), .item_t(logic)) u_present_fifo (
		.clk(clk),
		.reset(reset),
		.write(accept),
		.read(syn_handoff),
		.wdata(|error),
		.rdata(exp_present),
		.overflow(present_ovf)
	);

	assign new_wrong = pattern_ovf || count_ovf || present_ovf
		|| (syn_handoff && ((|{syn_s1, syn_s3}) != exp_present))
		|| (key_handoff && (key_count != exp_count))
		|| (result_valid && (result_pattern != exp_pattern));

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			wrong <= 1'b0;
		end else begin
			result_valid <= ch_last;
			if (new_wrong)
				wrong <= 1'b1; // Sticky.
		end
	end

endmodule

// ==== hw/bch_encode.sv ====
module bch_encode (
	input logic clk,
	input logic reset,
	input logic start,
	input logic accepted,
	input bch_pkg::data_t data_in,
	output logic data_out,
	output logic first,
	output logic last,
	output logic busy
);
	import bch_pkg::*;

	localparam int cnt_w = $clog2(code_n);

	logic [cnt_w-1:0] bit_cnt;
	data_t data_sr;
	logic [ecc_bits-1:0] lfsr;
	logic in_data;
	logic feedback;

	assign in_data = bit_cnt < cnt_w'(data_k);
	assign data_out = in_data ? data_sr[data_k-1] : lfsr[ecc_bits-1];
	assign first = busy && (bit_cnt == '0);
	assign last = busy && (bit_cnt == cnt_w'(code_n - 1));
	assign feedback = data_sr[data_k-1] ^ lfsr[ecc_bits-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			bit_cnt <= '0;
		end else if (start) begin
			busy <= 1'b1;
			bit_cnt <= '0;
		end else if (busy && accepted) begin
			bit_cnt <= last ? '0 : bit_cnt + 1'b1;
			if (last)
				busy <= 1'b0;
		end
	end

	// Data goes out MSB first while the divider runs.
	always_ff @(posedge clk) begin
		if (start) begin
			data_sr <= data_in;
			lfsr <= '0;
		end else if (busy && accepted) begin
			if (in_data) begin
				data_sr <= {data_sr[data_k-2:0], 1'b0};
				lfsr <= {lfsr[ecc_bits-2:0], 1'b0} ^ (feedback ? gen_poly[ecc_bits-1:0] : '0);
			end else begin
				lfsr <= {lfsr[ecc_bits-2:0], 1'b0}; // Parity out.
			end
		end
	end

endmodule

// ==== hw/expect_fifo.sv ====
module expect_fifo #(
	parameter int depth = 6,
	parameter type item_t = logic
) (
	input logic clk,
	input logic reset,
	input logic write,
	input logic read,
	input item_t wdata,
	output item_t rdata,
	output logic overflow
);

	localparam int ptr_w = $clog2(depth);

	item_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_next;
	logic [ptr_w-1:0] rd_next;

	assign wr_next = (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
	assign rd_next = (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
	assign rdata = mem[rd_ptr];
	assign overflow = write && (wr_next == rd_ptr); // Would wrap onto unread entry.

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (write)
				wr_ptr <= wr_next;
			if (read)
				rd_ptr <= rd_next;
		end
	end

	always_ff @(posedge clk) begin
		if (write)
			mem[wr_ptr] <= wdata;
	end

endmodule

// ==== verilog.f ====
common/bch_pkg.sv
hw/bch_encode.sv
bch_decode/bch_syndrome.sv
bch_decode/bch_key_dec.sv
bch_decode/bch_chien.sv
hw/expect_fifo.sv
hw/bch_codec_check.sv
dv/bch_tb.sv
